//--- verilog/eth_frame_pkg.sv
package eth_frame_pkg;

    // Header sizes in bytes
    localparam int eth_header_bytes  = 14;
    localparam int ipv4_header_bytes = 20;
    localparam int udp_header_bytes  = 8;
    localparam int fcs_bytes         = 4;

    // Field values the receive path accepts
    localparam logic [15:0] ethertype_ipv4    = 16'h0800;
    localparam logic [7:0]  ipv4_version_ihl  = 8'h45;
    localparam logic [7:0]  ipv4_protocol_udp = 8'd17;

    // Offset of the destination port inside the UDP header
    localparam int udp_dst_offset = 2;

    //////////////////////////////
    // Reflected CRC-32
    //////////////////////////////
    localparam logic [31:0] crc_poly    = 32'hEDB8_8320;
    localparam logic [31:0] crc_init    = 32'hFFFF_FFFF;
    // Bit-reversed register value after a good frame and its FCS
    localparam logic [31:0] crc_residue = 32'hC704_DD7B;

    typedef enum logic [2:0] {
        ps_idle,
        ps_header,
        ps_payload,
        ps_drop,
        ps_verdict
    } parser_state_e;

endpackage

//--- verilog/udp_port_pkg.sv
package udp_port_pkg;

    // Bit 8 flags the last byte of a frame or record
    typedef logic [8:0] port_word_t;

    typedef logic [15:0] udp_port_t;

    // Receive slot sequencing
    typedef enum logic [2:0] {
        hs_empty,
        hs_filling,
        hs_send_port_high,
        hs_send_port_low,
        hs_send_payload,
        hs_flush
    } handler_state_e;

endpackage

//--- verilog/port_ifs.sv
`timescale 1ns/10ps

// Byte stream into the CRC unit and its verdict
interface fcs_if;
    logic [7:0] data;
    logic       valid;
    logic       last;
    logic       good;
    logic       done;

    modport source (output data, valid, last, input good, done);
    modport check (input data, valid, last, output good, done);
endinterface

// Parser to one receive slot
interface slot_fill_if import udp_port_pkg::*; ();
    logic [7:0] wr_data;
    logic       wr_en;
    logic       frame_good;
    logic       frame_bad;
    udp_port_t  udp_dst;
    logic       free;

    modport parser (
        output wr_data, wr_en, frame_good, frame_bad, udp_dst,
        input  free
    );
    modport handler (
        input  wr_data, wr_en, frame_good, frame_bad, udp_dst,
        output free
    );
endinterface

//--- verilog/frame_check_sequence.sv
`timescale 1ns/10ps

module frame_check_sequence
    import eth_frame_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,
    fcs_if.check  fcs
);
    logic [31:0] crc;
    logic [31:0] crc_next;
    logic [31:0] crc_msb_first;

    function automatic logic [31:0] crc_byte(input logic [31:0] c_in, input logic [7:0] d);
        logic [31:0] c;
        c = c_in ^ {24'd0, d};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_next      = crc_byte(crc, fcs.data);
    assign crc_msb_first = {<<{crc_next}};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            crc      <= crc_init;
            fcs.done <= 1'b0;
            fcs.good <= 1'b0;
        end else begin
            fcs.done <= fcs.valid && fcs.last;
            if (fcs.valid && fcs.last) begin
                // Ready for the next frame straight away
                crc      <= crc_init;
                fcs.good <= crc_msb_first == crc_residue;
            end else if (fcs.valid) begin
                crc <= crc_next;
            end
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n) fcs.last |-> fcs.valid);

endmodule

//--- verilog/ethernet_frame_parser.sv
`timescale 1ns/10ps

module ethernet_frame_parser
    import eth_frame_pkg::*;
    import udp_port_pkg::*;
#(
    parameter int receive_slots = 2,
    parameter int payload_depth = 64
)(
    input  logic         clock,
    input  logic         arst_n,
    input  port_word_t   rx_data,
    input  logic         rx_valid,
    fcs_if.source        fcs,
    slot_fill_if.parser  slots [receive_slots]
);
    localparam int sel_w      = (receive_slots > 1) ? $clog2(receive_slots) : 1;
    localparam int cnt_w      = $clog2(payload_depth + 1);
    localparam int ipv4_start = eth_header_bytes;
    localparam int udp_start  = eth_header_bytes + ipv4_header_bytes;
    localparam int hdr_total  = udp_start + udp_header_bytes;

    parser_state_e             state;
    logic [15:0]               idx;
    logic                      accepted;
    logic                      hdr_bad;
    logic                      overflow;
    logic [sel_w-1:0]          slot_sel;
    logic [sel_w-1:0]          pend_slot;
    logic                      pend_bad;
    logic [cnt_w-1:0]          wr_count;
    logic [fcs_bytes-1:0][7:0] dly;
    logic [7:0]                wr_byte;
    udp_port_t                 udp_dst;
    logic [receive_slots-1:0]  slot_wr_en;
    logic [receive_slots-1:0]  slot_good;
    logic [receive_slots-1:0]  slot_bad;
    logic [receive_slots-1:0]  slot_free;
    logic                      any_avail;
    logic [sel_w-1:0]          first_avail;
    logic [7:0]                b;
    logic                      last;
    logic                      field_bad;
    logic                      short_now;
    logic                      write_due;
    logic                      ovf_now;

    assign b    = rx_data[7:0];
    assign last = rx_data[8];

    assign fcs.data  = b;
    assign fcs.valid = rx_valid;
    assign fcs.last  = last;

    for (genvar i = 0; i < receive_slots; i++) begin : g_slot
        assign slots[i].wr_data    = wr_byte;
        assign slots[i].wr_en      = slot_wr_en[i];
        assign slots[i].frame_good = slot_good[i];
        assign slots[i].frame_bad  = slot_bad[i];
        assign slots[i].udp_dst    = udp_dst;
        assign slot_free[i]        = slots[i].free;
    end

    //////////////////////////////
    // Header fields
    //////////////////////////////
    always_comb begin
        case (int'(idx))
            eth_header_bytes - 2: field_bad = b != ethertype_ipv4[15:8];
            eth_header_bytes - 1: field_bad = b != ethertype_ipv4[7:0];
            ipv4_start:           field_bad = b != ipv4_version_ihl;
            ipv4_start + 9:       field_bad = b != ipv4_protocol_udp;
            default:              field_bad = 1'b0;
        endcase
    end

    assign short_now = last && (int'(idx) < hdr_total + fcs_bytes - 1);
    // FCS bytes stay behind in the delay line
    assign write_due = rx_valid && state == ps_payload && int'(idx) >= hdr_total + fcs_bytes;
    assign ovf_now   = write_due && int'(wr_count) == payload_depth;

    // Lowest free slot whose verdict is no longer in flight
    always_comb begin
        any_avail   = 1'b0;
        first_avail = '0;
        for (int i = receive_slots - 1; i >= 0; i--) begin
            if (slot_free[i] && !slot_good[i] && !slot_bad[i]
                    && !(state == ps_verdict && int'(pend_slot) == i)) begin
                any_avail   = 1'b1;
                first_avail = sel_w'(i);
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ps_idle;
            idx        <= '0;
            accepted   <= 1'b0;
            hdr_bad    <= 1'b0;
            overflow   <= 1'b0;
            slot_sel   <= '0;
            pend_slot  <= '0;
            pend_bad   <= 1'b0;
            wr_count   <= '0;
            slot_wr_en <= '0;
            slot_good  <= '0;
            slot_bad   <= '0;
        end else begin
            slot_wr_en <= '0;
            slot_good  <= '0;
            slot_bad   <= '0;
            if (state == ps_verdict && fcs.done) begin
                slot_good[pend_slot] <= !pend_bad && fcs.good;
                slot_bad[pend_slot]  <= pend_bad || !fcs.good;
            end
            if (rx_valid) begin
                idx <= last ? 16'd0 : idx + 16'd1;
            end
            if (rx_valid && last) begin
                pend_slot <= (state == ps_idle || state == ps_verdict) ? first_avail : slot_sel;
                pend_bad  <= hdr_bad || field_bad || short_now || overflow || ovf_now;
            end
            if (ovf_now) begin
                overflow <= 1'b1;
            end else if (write_due) begin
                slot_wr_en[slot_sel] <= 1'b1;
                wr_count             <= wr_count + 1'b1;
            end
            case (state)
                ps_idle, ps_verdict: begin
                    state <= ps_idle;
                    if (rx_valid) begin
                        accepted <= any_avail;
                        slot_sel <= first_avail;
                        hdr_bad  <= 1'b0;
                        overflow <= 1'b0;
                        wr_count <= '0;
                        if (any_avail) begin
                            state <= last ? ps_verdict : ps_header;
                        end else begin
                            state <= last ? ps_idle : ps_drop;
                        end
                    end
                end
                ps_header: begin
                    if (rx_valid && last) begin
                        state <= ps_verdict;
                    end else if (rx_valid && field_bad) begin
                        hdr_bad <= 1'b1;
                        state   <= ps_drop;
                    end else if (rx_valid && int'(idx) == hdr_total - 1) begin
                        state <= ps_payload;
                    end
                end
                ps_payload: if (rx_valid && last) state <= ps_verdict;
                ps_drop:    if (rx_valid && last) state <= accepted ? ps_verdict : ps_idle;
                default:    state <= ps_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rx_valid && state == ps_header) begin
            if (int'(idx) == udp_start + udp_dst_offset) udp_dst[15:8] <= b;
            if (int'(idx) == udp_start + udp_dst_offset + 1) udp_dst[7:0] <= b;
        end
        if (rx_valid) begin
            dly <= {dly[fcs_bytes-2:0], b};
        end
        if (write_due) begin
            wr_byte <= dly[fcs_bytes-1];
        end
    end

    // CRC verdict must be ready when the parser asks for it
    assert property (@(posedge clock) disable iff (!arst_n) state == ps_verdict |-> fcs.done);

endmodule

//--- verilog/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo #(
    parameter int width = 8,
    parameter int depth = 64
)(
    input  logic             clock,
    input  logic             arst_n,
    input  logic [width-1:0] wr_data,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             rd_valid,
    output logic             empty,
    output logic             full,
    input  logic             flush
);
    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    logic [width-1:0] mem [depth];
    logic [aw-1:0]    wr_ptr;
    logic [aw-1:0]    rd_ptr;
    logic [aw:0]      count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;
    assign empty = count == '0;
    assign full  = count == (aw + 1)'(depth);

    always_ff @(posedge clock) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
        if (do_rd) rd_data <= mem[rd_ptr];
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else if (flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            // Read data shows up one cycle after the pop
            rd_valid <= do_rd;
            if (do_wr) wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            count <= count + (aw + 1)'(do_wr) - (aw + 1)'(do_rd);
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n) !(wr_en && full));

endmodule

//--- verilog/udp_receive_handler.sv
`timescale 1ns/10ps

module udp_receive_handler
    import udp_port_pkg::*;
#(
    parameter int payload_depth = 64
)(
    input  logic          clock,
    input  logic          arst_n,
    slot_fill_if.handler  fill,
    output logic          req,
    output port_word_t    word,
    input  logic          grant
);
    handler_state_e state;
    udp_port_t      port;
    logic [7:0]     rd_data;
    logic           rd_valid;
    logic           fifo_empty;
    logic           held;
    logic           have;
    logic           pop;

    byte_fifo #(
        .width (8),
        .depth (payload_depth)
    ) u_payload_fifo (
        .clock    (clock),
        .arst_n   (arst_n),
        .wr_data  (fill.wr_data),
        .wr_en    (fill.wr_en),
        .rd_en    (pop),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .empty    (fifo_empty),
        .full     (),
        .flush    (state == hs_flush)
    );

    // Next payload byte is fetched as soon as the current word moves
    assign pop  = grant && !fifo_empty
               && (state == hs_send_port_low || state == hs_send_payload);
    assign have = rd_valid || held;
    assign fill.free = state == hs_empty && fifo_empty;

    always_comb begin
        req  = 1'b0;
        word = '0;
        case (state)
            hs_send_port_high: begin
                req  = 1'b1;
                word = {1'b0, port[15:8]};
            end
            hs_send_port_low: begin
                req  = 1'b1;
                word = {fifo_empty, port[7:0]};
            end
            hs_send_payload: begin
                req  = have;
                word = {fifo_empty, rd_data};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= hs_empty;
            held  <= 1'b0;
        end else begin
            held <= have && !(grant && state == hs_send_payload);
            case (state)
                hs_empty, hs_filling: begin
                    if (fill.frame_good) state <= hs_send_port_high;
                    else if (fill.frame_bad) state <= hs_flush;
                    else if (fill.wr_en) state <= hs_filling;
                end
                hs_send_port_high: if (grant) state <= hs_send_port_low;
                hs_send_port_low, hs_send_payload: begin
                    if (grant) state <= fifo_empty ? hs_empty : hs_send_payload;
                end
                default: state <= hs_empty;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fill.frame_good) port <= fill.udp_dst;
    end

endmodule

//--- verilog/receive_slot_arbiter.sv
`timescale 1ns/10ps

module receive_slot_arbiter
    import udp_port_pkg::*;
#(
    parameter int receive_slots = 2
)(
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic [receive_slots-1:0] req,
    input  port_word_t               word [receive_slots],
    output logic [receive_slots-1:0] grant,
    output port_word_t               out_word,
    output logic                     out_push,
    input  logic                     out_full
);
    localparam int sel_w = (receive_slots > 1) ? $clog2(receive_slots) : 1;

    logic             locked;
    logic [sel_w-1:0] owner;
    logic [sel_w-1:0] rr_ptr;
    logic [sel_w-1:0] pick;
    logic             found;

    // Locked slot keeps the output until its record ends
    always_comb begin
        found = 1'b0;
        pick  = owner;
        if (locked) begin
            found = req[owner];
        end else begin
            for (int k = 0; k < receive_slots; k++) begin
                if (!found && req[(int'(rr_ptr) + k) % receive_slots]) begin
                    found = 1'b1;
                    pick  = sel_w'((int'(rr_ptr) + k) % receive_slots);
                end
            end
        end
    end

    assign out_push = found && !out_full;
    assign grant    = out_push ? (receive_slots'(1) << pick) : '0;
    assign out_word = word[pick];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            locked <= 1'b0;
            owner  <= '0;
            rr_ptr <= '0;
        end else if (out_push) begin
            owner  <= pick;
            locked <= !out_word[8];
            if (out_word[8]) rr_ptr <= (int'(pick) == receive_slots - 1) ? '0 : pick + 1'b1;
        end
    end

    // A slot in the middle of its record keeps presenting words
    assert property (@(posedge clock) disable iff (!arst_n) locked |-> req[owner]);

endmodule

//--- verilog/virtual_port_udp.sv
`timescale 1ns/10ps

module virtual_port_udp
    import udp_port_pkg::*;
#(
    parameter int receive_slots  = 2,
    parameter int payload_depth  = 64,
    parameter int outbound_depth = 32
)(
    input  logic       clock,
    input  logic       arst_n,
    input  port_word_t virtual_port_receive_data,
    input  logic       virtual_port_receive_data_enable,
    input  logic       receive_data_enable,
    output port_word_t receive_data,
    output logic       receive_data_valid
);
    fcs_if       fcs_bus ();
    slot_fill_if fill_bus [receive_slots] ();

    logic [receive_slots-1:0] slot_req;
    logic [receive_slots-1:0] slot_grant;
    port_word_t               slot_word [receive_slots];
    port_word_t               out_word;
    logic                     out_push;
    logic                     out_full;

    frame_check_sequence u_fcs (
        .clock  (clock),
        .arst_n (arst_n),
        .fcs    (fcs_bus)
    );

    ethernet_frame_parser #(
        .receive_slots (receive_slots),
        .payload_depth (payload_depth)
    ) u_parser (
        .clock    (clock),
        .arst_n   (arst_n),
        .rx_data  (virtual_port_receive_data),
        .rx_valid (virtual_port_receive_data_enable),
        .fcs      (fcs_bus),
        .slots    (fill_bus)
    );

    //////////////////////////////
    // Receive slots
    //////////////////////////////
    for (genvar i = 0; i < receive_slots; i++) begin : g_slot
        udp_receive_handler #(
            .payload_depth (payload_depth)
        ) u_handler (
            .clock  (clock),
            .arst_n (arst_n),
            .fill   (fill_bus[i]),
            .req    (slot_req[i]),
            .word   (slot_word[i]),
            .grant  (slot_grant[i])
        );
    end

    receive_slot_arbiter #(
        .receive_slots (receive_slots)
    ) u_arbiter (
        .clock    (clock),
        .arst_n   (arst_n),
        .req      (slot_req),
        .word     (slot_word),
        .grant    (slot_grant),
        .out_word (out_word),
        .out_push (out_push),
        .out_full (out_full)
    );

    byte_fifo #(
        .width ($bits(port_word_t)),
        .depth (outbound_depth)
    ) u_outbound_fifo (
        .clock    (clock),
        .arst_n   (arst_n),
        .wr_data  (out_word),
        .wr_en    (out_push),
        .rd_en    (receive_data_enable),
        .rd_data  (receive_data),
        .rd_valid (receive_data_valid),
        .empty    (),
        .full     (out_full),
        .flush    (1'b0)
    );

endmodule

//--- sim/virtual_port_udp_tb.sv
`timescale 1ns/10ps

module virtual_port_udp_tb
    import eth_frame_pkg::*;
    import udp_port_pkg::*;
();
    localparam int num_frames = 12;
    localparam int max_record = 80;

    typedef enum logic [2:0] {
        fault_none,
        fault_bad_fcs,
        fault_ethertype,
        fault_not_udp,
        fault_oversize
    } fault_e;

    typedef struct packed {
        logic [7:0] len;
        udp_port_t  port;
        fault_e     fault;
        logic [7:0] gap;
    } frame_entry_t;

    // Payload length, destination port, fault, idle cycles after the frame
    localparam frame_entry_t stimulus [num_frames] = '{
        '{8'd18, 16'h1234, fault_none,      8'd6},
        '{8'd1,  16'h0035, fault_none,      8'd10},
        '{8'd24, 16'h2001, fault_bad_fcs,   8'd4},
        '{8'd20, 16'h2002, fault_none,      8'd8},
        '{8'd16, 16'h2003, fault_ethertype, 8'd4},
        '{8'd16, 16'h2004, fault_not_udp,   8'd4},
        '{8'd64, 16'h2005, fault_none,      8'd12},
        '{8'd70, 16'h2006, fault_oversize,  8'd8},
        '{8'd12, 16'h3001, fault_none,      8'd0},
        '{8'd30, 16'h3002, fault_none,      8'd0},
        '{8'd8,  16'h3003, fault_none,      8'd0},
        '{8'd22, 16'h3004, fault_none,      8'd20}
    };

    logic       clock = 1'b0;
    logic       arst_n;
    port_word_t virtual_port_receive_data;
    logic       virtual_port_receive_data_enable;
    logic       receive_data_enable;
    port_word_t receive_data;
    logic       receive_data_valid;

    integer     seed = 32'hbbf0_c451;
    int         cycle_count = 0;
    int         cycle_limit;
    int         records_expected;
    int         records_seen;
    logic [7:0] frame_bytes [$];
    port_word_t got [$];
    port_word_t exp_words [num_frames][max_record];
    int         exp_len [num_frames];
    logic       exp_open [num_frames];

    virtual_port_udp #(
        .receive_slots  (2),
        .payload_depth  (64),
        .outbound_depth (32)
    ) u_dut (
        .clock                            (clock),
        .arst_n                           (arst_n),
        .virtual_port_receive_data        (virtual_port_receive_data),
        .virtual_port_receive_data_enable (virtual_port_receive_data_enable),
        .receive_data_enable              (receive_data_enable),
        .receive_data                     (receive_data),
        .receive_data_valid               (receive_data_valid)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles, %0d of %0d records received",
                                        cycle_count, records_seen, records_expected));
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    function automatic int total_table_bytes();
        int sum;
        sum = 0;
        for (int e = 0; e < num_frames; e++) begin
            sum += eth_header_bytes + ipv4_header_bytes + udp_header_bytes + fcs_bytes;
            sum += int'(stimulus[e].len) + int'(stimulus[e].gap);
        end
        return sum;
    endfunction

    // Inverted Ethernet CRC-32 of the bytes built so far
    function automatic logic [31:0] frame_crc32();
        logic [31:0] c;
        c = crc_init;
        for (int i = 0; i < frame_bytes.size(); i++) begin
            c = c ^ {24'd0, frame_bytes[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic push_u16(input logic [15:0] v);
        frame_bytes.push_back(v[15:8]);
        frame_bytes.push_back(v[7:0]);
    endtask

    task automatic build_frame(input int e);
        frame_entry_t ent;
        logic [31:0]  fcs;
        logic [7:0]   b;
        int           len;
        ent = stimulus[e];
        len = int'(ent.len);
        frame_bytes.delete();
        // MAC addresses
        push_u16(16'h0200);
        push_u16(16'h0000);
        push_u16(16'h0001);
        push_u16(16'h0200);
        push_u16(16'h0000);
        push_u16(16'(e));
        push_u16(ent.fault == fault_ethertype ? 16'h86dd : ethertype_ipv4);
        //////////////////////////////
        // IPv4 header, no options
        //////////////////////////////
        frame_bytes.push_back(ipv4_version_ihl);
        frame_bytes.push_back(8'h00);
        push_u16(16'(ipv4_header_bytes + udp_header_bytes + len));
        push_u16(16'h0000);
        push_u16(16'h4000);
        frame_bytes.push_back(8'd64);
        frame_bytes.push_back(ent.fault == fault_not_udp ? 8'd6 : ipv4_protocol_udp);
        push_u16(16'h0000);
        push_u16(16'hc0a8);
        push_u16(16'h000a);
        push_u16(16'hc0a8);
        push_u16(16'h0001);
        // UDP header
        push_u16(16'h4000 + 16'(e));
        push_u16(ent.port);
        push_u16(16'(udp_header_bytes + len));
        push_u16(16'h0000);
        exp_words[e][0] = {1'b0, ent.port[15:8]};
        exp_words[e][1] = {1'b0, ent.port[7:0]};
        for (int k = 0; k < len; k++) begin
            b = 8'($random(seed));
            frame_bytes.push_back(b);
            exp_words[e][k + 2] = {k == len - 1, b};
        end
        fcs = frame_crc32();
        if (ent.fault == fault_bad_fcs) fcs = fcs ^ 32'h0000_0100;
        for (int k = 0; k < fcs_bytes; k++) begin
            frame_bytes.push_back(fcs[8*k +: 8]);
        end
        if (ent.fault == fault_none) begin
            exp_open[e] = 1'b1;
            exp_len[e]  = len + 2;
            records_expected++;
        end
    endtask

    // Records may arrive in any order, so look one up by port and length
    task automatic match_record();
        int hit;
        hit = -1;
        for (int e = num_frames - 1; e >= 0; e--) begin
            if (exp_open[e] && exp_len[e] == got.size()
                    && exp_words[e][0] == got[0] && exp_words[e][1] == got[1]) begin
                hit = e;
            end
        end
        if (hit < 0) begin
            stop_with_failure($sformatf("Output record of %0d words matches no expected frame",
                                        got.size()));
        end else begin
            for (int k = 0; k < exp_len[hit]; k++) begin
                check_value($sformatf("receive_data word %0d of port %h", k, stimulus[hit].port),
                            32'(got[k]), 32'(exp_words[hit][k]));
            end
            exp_open[hit] = 1'b0;
            records_seen++;
            got.delete();
        end
    endtask

    task automatic collect_output();
        if (receive_data_valid && !receive_data_enable) begin
            stop_with_failure("receive_data_valid came without a pop in the cycle before");
        end else if (receive_data_valid) begin
            got.push_back(receive_data);
            if (got.size() > max_record) begin
                stop_with_failure("Output record is longer than any frame sent");
            end else if (receive_data[8]) begin
                match_record();
            end
        end
    endtask

    // Sample outputs on the falling edge, then drive the next inputs
    task run_cycle(input port_word_t rx_word, input logic rx_en, input logic pops_on);
        @(negedge clock);
        collect_output();
        receive_data_enable              = pops_on && (($random(seed) & 3) != 0);
        virtual_port_receive_data        = rx_word;
        virtual_port_receive_data_enable = rx_en;
    endtask

    initial begin
        int n;
        cycle_limit                      = 8 * total_table_bytes() + 500;
        arst_n                           = 1'b0;
        virtual_port_receive_data        = '0;
        virtual_port_receive_data_enable = 1'b0;
        receive_data_enable              = 1'b0;
        records_expected                 = 0;
        records_seen                     = 0;
        for (int e = 0; e < num_frames; e++) begin
            exp_open[e] = 1'b0;
            exp_len[e]  = 0;
        end
        repeat (5) @(negedge clock);
        arst_n = 1'b1;
        check_value("receive_data_valid", 32'(receive_data_valid), 32'd0);

        for (int e = 0; e < num_frames; e++) begin
            build_frame(e);
            n = frame_bytes.size();
            for (int k = 0; k < n; k++) begin
                run_cycle({k == n - 1, frame_bytes[k]}, 1'b1, 1'b1);
            end
            repeat (int'(stimulus[e].gap)) run_cycle('0, 1'b0, 1'b1);
        end

        // Drain, then stop popping and watch for stray output
        while (records_seen < records_expected) begin
            run_cycle('0, 1'b0, 1'b1);
        end
        repeat (40) run_cycle('0, 1'b0, 1'b0);

        if (records_seen == records_expected && got.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_failure("Output stream ended inside a record");
        end
    end

endmodule

//--- list.f
verilog/eth_frame_pkg.sv
verilog/udp_port_pkg.sv
verilog/port_ifs.sv
verilog/frame_check_sequence.sv
verilog/ethernet_frame_parser.sv
verilog/byte_fifo.sv
verilog/udp_receive_handler.sv
verilog/receive_slot_arbiter.sv
verilog/virtual_port_udp.sv
sim/virtual_port_udp_tb.sv

//--- Makefile
TOP = virtual_port_udp_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^Verification passed$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module virtual_port_udp -f list.f

clean:
	rm -rf obj_dir
